// File: srt_div.f
rtl/srt_div_pkg.sv
rtl/div_lzc.sv
rtl/div_prescale.sv
rtl/div_qds.sv
rtl/div_iter.sv
rtl/div_post.sv
rtl/srt_div.sv
test/srt_div_properties.sv
test/srt_div_tb.sv

// File: Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the divider testbench"
	@echo "make clean  remove the build directory and the log"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -f srt_div.f --top-module srt_div_tb \
		-Mdir obj_dir -o srt_div_sim
	./obj_dir/srt_div_sim > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qF '*** TEST FAILED ***' $(LOG); then echo "test failed"; exit 1; fi
	@grep -qF '*** TEST PASSED ***' $(LOG) || { echo "run ended without a result"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)

// File: test/srt_div_tb.sv
`timescale 1ns/1ps

module srt_div_tb;

	localparam int XLEN    = 32;
	localparam int NUM_DIV = 400; // six directed divisions, the rest random
	localparam int TIMEOUT = NUM_DIV * 40; // a division with stalls stays far below 40 cycles

	logic            clock = 1'b0;
	logic            reset_i;
	logic            in_valid_i;
	logic            in_ready_o;
	logic            signed_i;
	logic [XLEN-1:0] dividend_i;
	logic [XLEN-1:0] divisor_i;
	logic            out_valid_o;
	logic            out_ready_i;
	logic [XLEN-1:0] quot_o;
	logic [XLEN-1:0] rem_o;
	logic [31:0]     lfsr_q = 32'h298b_00db;
	logic [2*XLEN:0] ops[NUM_DIV]; // {signed, dividend, divisor} in the order they are offered
	logic [2*XLEN:0] pending_q[$]; // {signed, dividend, divisor} of accepted inputs, oldest first
	int              num_results = 0;
	int              cycle_cnt = 0;

	srt_div #(.XLEN(XLEN)) srt_div_inst (
		.clock(clock), .reset_i(reset_i), .in_valid_i(in_valid_i), .in_ready_o(in_ready_o),
		.signed_i(signed_i), .dividend_i(dividend_i), .divisor_i(divisor_i),
		.out_valid_o(out_valid_o), .out_ready_i(out_ready_i), .quot_o(quot_o), .rem_o(rem_o)
	);

	bind srt_div srt_div_properties #(.XLEN(XLEN)) props_inst (
		.clock(clock), .reset_i(reset_i), .in_ready_i(in_ready_o), .out_valid_i(out_valid_o),
		.out_ready_i(out_ready_i), .quot_i(quot_o), .rem_i(rem_o)
	);

	always #5 clock = ~clock; // 10 ns period

	task automatic fail_now(input string why);
		$display("%s", why);
		$display("*** TEST FAILED ***");
		$fatal(1, "simulation stopped at the first error");
	endtask

	// taps 32, 22, 2, 1 give a maximal-length sequence
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic draw_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_next(lfsr_q); // one step per bit taken
			v = {v[30:0], lfsr_q[0]};
		end
	endtask

	function automatic logic [XLEN-1:0] edge_value(input logic [1:0] pick);
		case (pick)
			2'd0: return '0;
			2'd1: return 1;
			2'd2: return '1; // minus one in signed mode
			default: return {1'b1, {(XLEN-1){1'b0}}}; // most negative value
		endcase
	endfunction

	// truncating division with the remainder on the dividend's side, all-ones on a zero divisor
	function automatic logic [2*XLEN-1:0] ref_divide(input logic sgn, input logic [XLEN-1:0] a,
	                                                 input logic [XLEN-1:0] b);
		logic            a_neg;
		logic            b_neg;
		logic [XLEN-1:0] a_mag;
		logic [XLEN-1:0] b_mag;
		logic [XLEN-1:0] q;
		logic [XLEN-1:0] r;
		a_neg = sgn & a[XLEN-1];
		b_neg = sgn & b[XLEN-1];
		a_mag = a_neg ? -a : a; // most negative value keeps its magnitude when read unsigned
		b_mag = b_neg ? -b : b;
		if (b == '0) return {{XLEN{1'b1}}, a};
		q = a_mag / b_mag;
		r = a_mag % b_mag;
		q = (a_neg ^ b_neg) ? -q : q;
		r = a_neg ? -r : r;
		return {q, r};
	endfunction

	task automatic check_result();
		logic [2*XLEN:0]   op;
		logic [2*XLEN-1:0] exp;
		assert (pending_q.size() > 0) else fail_now("a result came out with no division pending");
		op  = pending_q.pop_front(); // results must come back in input order
		exp = ref_divide(op[2*XLEN], op[2*XLEN-1:XLEN], op[XLEN-1:0]);
		assert (quot_o == exp[2*XLEN-1:XLEN]) else fail_now($sformatf(
			"MISMATCH at %0t: signed=%0b %h / %h gave quotient %h, expected %h", $time,
			op[2*XLEN], op[2*XLEN-1:XLEN], op[XLEN-1:0], quot_o, exp[2*XLEN-1:XLEN]));
		assert (rem_o == exp[XLEN-1:0]) else fail_now($sformatf(
			"MISMATCH at %0t: signed=%0b %h / %h gave remainder %h, expected %h", $time,
			op[2*XLEN], op[2*XLEN-1:XLEN], op[XLEN-1:0], rem_o, exp[XLEN-1:0]));
		num_results++;
	endtask

	// both handshakes are settled by the falling edge, so transfers are seen without races
	always @(negedge clock) begin
		if (!reset_i && in_valid_i && in_ready_o) begin
			pending_q.push_back({signed_i, dividend_i, divisor_i});
		end
		if (!reset_i && out_valid_o && out_ready_i) begin
			check_result();
		end
	end

	always @(posedge clock) begin
		cycle_cnt++;
		if (cycle_cnt > TIMEOUT) begin
			fail_now($sformatf("timeout: the run did not finish within %0d cycles", TIMEOUT));
		end
	end

	initial begin
		logic [31:0] cls;
		logic [31:0] sgn;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] sh;
		logic [31:0] r;
		logic        taken;
		int          sent;
		reset_i     = 1'b1;
		in_valid_i  = 1'b0;
		signed_i    = 1'b0;
		dividend_i  = '0;
		divisor_i   = '0;
		out_ready_i = 1'b0;
		ops[0] = {1'b1, 32'h8000_0000, 32'hffff_ffff}; // signed overflow gives the dividend back
		ops[1] = {1'b0, 32'd12345, 32'd0};
		ops[2] = {1'b1, 32'hffff_fff9, 32'd0}; // -7 by zero
		ops[3] = {1'b0, 32'd3, 32'd1000}; // iterations skipped
		ops[4] = {1'b1, 32'hffff_fffd, 32'd1000};
		ops[5] = {1'b1, 32'd100, 32'hffff_fff9}; // 100 by -7
		for (int i = 6; i < NUM_DIV; i++) begin
			draw_bits(2, cls); // operand shape
			draw_bits(1, sgn);
			draw_bits(32, a);
			draw_bits(5, sh);
			case (cls[1:0])
				2'd0: begin
					draw_bits(32, b);
					b = b >> sh[4:0]; // spread the leading-zero difference
					draw_bits(5, sh);
					a = a >> sh[4:0];
				end
				2'd1: begin
					draw_bits(4, b);
					b = b + 1;
					if (sgn[0] && sh[0]) b = -b;
				end
				2'd2: b = '0;
				default: begin
					a = edge_value(sh[1:0]);
					b = edge_value(sh[3:2]);
				end
			endcase
			ops[i] = {sgn[0], a, b};
		end
		repeat (2) @(posedge clock);
		#1;
		reset_i    = 1'b0;
		sent       = 0;
		in_valid_i = 1'b1;
		{signed_i, dividend_i, divisor_i} = ops[0];
		while (num_results < NUM_DIV) begin
			draw_bits(2, r);
			out_ready_i = (r[1:0] != 2'b00); // consumer stalls about one cycle in four
			@(negedge clock);
			taken = in_valid_i && in_ready_o;
			@(posedge clock);
			#1;
			if (taken) begin
				sent++;
				if (sent < NUM_DIV) begin
					{signed_i, dividend_i, divisor_i} = ops[sent]; // offered while the DUT is busy
				end else begin
					in_valid_i = 1'b0;
					dividend_i = ~dividend_i; // operands after acceptance must not reach the result
					divisor_i  = ~divisor_i;
				end
			end
		end
		out_ready_i = 1'b1;
		repeat (4) @(posedge clock); // a repeated result would find no division pending
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

// File: test/srt_div_properties.sv
`timescale 1ns/1ps

module srt_div_properties #(
	parameter int XLEN = 32
) (
	input logic            clock,
	input logic            reset_i,
	input logic            in_ready_i,
	input logic            out_valid_i,
	input logic            out_ready_i,
	input logic [XLEN-1:0] quot_i,
	input logic [XLEN-1:0] rem_i
);

	// ready belongs to IDLE and valid to DONE, so they never overlap
	no_ready_with_valid: assert property (@(posedge clock) disable iff (reset_i)
		!(in_ready_i && out_valid_i)) else $error("in_ready and out_valid high together");

	// a stalled result keeps its valid and its value
	result_held: assert property (@(posedge clock) disable iff (reset_i)
		(out_valid_i && !out_ready_i) |=> (out_valid_i && $stable(quot_i) && $stable(rem_i)))
		else $error("result changed while the consumer stalled");

	idle_after_reset: assert property (@(posedge clock) reset_i |=> !out_valid_i)
		else $error("out_valid high on the cycle after reset");

endmodule

// File: rtl/srt_div.sv
`timescale 1ns/1ps

module srt_div import srt_div_pkg::*; #(
	parameter int XLEN = 32
) (
	input  logic            clock,
	input  logic            reset_i,
	input  logic            in_valid_i,
	output logic            in_ready_o,
	input  logic            signed_i,
	input  logic [XLEN-1:0] dividend_i,
	input  logic [XLEN-1:0] divisor_i,
	output logic            out_valid_o,
	input  logic            out_ready_i,
	output logic [XLEN-1:0] quot_o,
	output logic [XLEN-1:0] rem_o
);

	localparam int RW    = XLEN + REM_GUARD;
	localparam int LZC_W = $clog2(XLEN);

	div_state_e       state_q;
	div_state_e       state_nxt;
	logic             accept;
	logic             skip;
	logic [XLEN-1:0]  dividend_norm;
	logic [XLEN-1:0]  divisor_norm;
	logic [LZC_W-1:0] dividend_lzc;
	logic [LZC_W-1:0] divisor_lzc;
	logic [LZC_W-1:0] lzc_diff;
	logic             rem_neg;
	logic             quot_neg;
	logic             div_zero;
	logic             too_small;
	logic [RW-1:0]    rem_sum;
	logic [RW-1:0]    rem_carry;
	logic [4:0]       init_rem_top;
	quot_digit_e      prev_digit;
	quot_digit_e      digit;
	quot_digit_e      init_digit;
	logic [XLEN-1:0]  quot;
	logic [XLEN-1:0]  quot_m1;
	logic             iter_done;

	assign in_ready_o  = (state_q == IDLE);
	assign out_valid_o = (state_q == DONE);
	assign accept      = in_valid_i & in_ready_o;
	assign skip        = div_zero | too_small; // flags are settled once NORM is over
	assign lzc_diff    = divisor_lzc - dividend_lzc; // only meaningful when not skipping

	// 4w0 in 1/16 units, matching the remainder load in div_iter
	assign init_rem_top = lzc_diff[0] ? {2'b00, dividend_norm[XLEN-1 -: 3]}
	                                  : {1'b0, dividend_norm[XLEN-1 -: 4]};

	always_comb begin
		unique case (state_q)
			IDLE:    state_nxt = accept ? NORM : IDLE;
			NORM:    state_nxt = INIT;
			INIT:    state_nxt = skip ? FIX : ITER;
			ITER:    state_nxt = iter_done ? FIX : ITER;
			FIX:     state_nxt = DONE;
			DONE:    state_nxt = out_ready_i ? IDLE : DONE; // hold the result under back-pressure
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset_i) begin
			state_q <= IDLE;
		end else begin
			state_q <= state_nxt;
		end
	end

	div_prescale #(.XLEN(XLEN)) u_prescale (
		.clock(clock), .reset_i(reset_i), .state_i(state_q), .accept_i(accept),
		.signed_i(signed_i), .dividend_i(dividend_i), .divisor_i(divisor_i),
		.dividend_norm_o(dividend_norm), .divisor_norm_o(divisor_norm),
		.dividend_lzc_o(dividend_lzc), .divisor_lzc_o(divisor_lzc),
		.rem_neg_o(rem_neg), .quot_neg_o(quot_neg), .div_zero_o(div_zero), .too_small_o(too_small)
	);

	div_qds #(.XLEN(XLEN)) u_qds (
		.divisor_norm_i(divisor_norm),
		.rem_sum_top_i(rem_sum[XLEN+1 -: 8]), // these bits become the top of 4w next step
		.rem_carry_top_i(rem_carry[XLEN+1 -: 8]),
		.prev_digit_i(prev_digit), .init_rem_top_i(init_rem_top),
		.digit_o(digit), .init_digit_o(init_digit)
	);

	div_iter #(.XLEN(XLEN)) u_iter (
		.clock(clock), .reset_i(reset_i), .state_i(state_q),
		.dividend_norm_i(dividend_norm), .divisor_norm_i(divisor_norm), .lzc_diff_i(lzc_diff),
		.digit_i(digit), .init_digit_i(init_digit),
		.rem_sum_o(rem_sum), .rem_carry_o(rem_carry), .prev_digit_o(prev_digit),
		.quot_o(quot), .quot_m1_o(quot_m1), .iter_done_o(iter_done)
	);

	div_post #(.XLEN(XLEN)) u_post (
		.clock(clock), .reset_i(reset_i), .state_i(state_q),
		.rem_sum_i(rem_sum), .rem_carry_i(rem_carry), .divisor_norm_i(divisor_norm),
		.divisor_lzc_i(divisor_lzc), .dividend_i(dividend_i), .quot_i(quot), .quot_m1_i(quot_m1),
		.rem_neg_i(rem_neg), .quot_neg_i(quot_neg), .div_zero_i(div_zero), .too_small_i(too_small),
		.quot_o(quot_o), .rem_o(rem_o)
	);

endmodule

// File: rtl/div_post.sv
`timescale 1ns/1ps

module div_post import srt_div_pkg::*; #(
	parameter int XLEN = 32
) (
	input  logic                      clock,
	input  logic                      reset_i,
	input  div_state_e                state_i,
	input  logic [XLEN+REM_GUARD-1:0] rem_sum_i,
	input  logic [XLEN+REM_GUARD-1:0] rem_carry_i,
	input  logic [XLEN-1:0]           divisor_norm_i,
	input  logic [$clog2(XLEN)-1:0]   divisor_lzc_i,
	input  logic [XLEN-1:0]           dividend_i,
	input  logic [XLEN-1:0]           quot_i,
	input  logic [XLEN-1:0]           quot_m1_i,
	input  logic                      rem_neg_i,
	input  logic                      quot_neg_i,
	input  logic                      div_zero_i,
	input  logic                      too_small_i,
	output logic [XLEN-1:0]           quot_o,
	output logic [XLEN-1:0]           rem_o
);

	localparam int RW = XLEN + REM_GUARD;

	logic [RW-1:0]   rem_res; // non-redundant final remainder
	logic [RW-1:0]   rem_plus_d;
	logic            need_corr;
	logic            corr_q;
	logic [XLEN-1:0] rem_abs_q; // corrected remainder, still normalized
	logic [XLEN-1:0] dividend_q;
	logic [XLEN-1:0] rem_abs;
	logic [XLEN-1:0] quot_abs;

	assign rem_res    = rem_sum_i + rem_carry_i;
	assign rem_plus_d = rem_res + {1'b0, divisor_norm_i, {(REM_GUARD-1){1'b0}}};
	assign need_corr  = rem_res[RW-1]; // negative remainder means the quotient overshot by one

	always_ff @(posedge clock) begin
		if (state_i == IDLE) begin
			dividend_q <= dividend_i; // last sample before leaving IDLE is the accepted one
		end
		if (state_i == FIX) begin
			rem_abs_q <= need_corr ? rem_plus_d[RW-2:REM_GUARD-1] : rem_res[RW-2:REM_GUARD-1];
		end
	end

	always_ff @(posedge clock) begin
		if (reset_i) begin
			corr_q <= 1'b0;
		end else if (state_i == FIX) begin
			corr_q <= need_corr;
		end
	end

	assign quot_abs = corr_q ? quot_m1_i : quot_i; // iteration registers hold still after ITER
	assign rem_abs  = rem_abs_q >> divisor_lzc_i; // undo the divisor normalization

	always_comb begin
		if (div_zero_i) begin
			quot_o = '1;
			rem_o  = dividend_q;
		end else if (too_small_i) begin
			quot_o = '0;
			rem_o  = dividend_q;
		end else begin
			quot_o = quot_neg_i ? -quot_abs : quot_abs;
			rem_o  = rem_neg_i ? -rem_abs : rem_abs; // sign follows the dividend
		end
	end

endmodule

// File: rtl/div_iter.sv
`timescale 1ns/1ps

module div_iter import srt_div_pkg::*; #(
	parameter int XLEN = 32
) (
	input  logic                      clock,
	input  logic                      reset_i,
	input  div_state_e                state_i,
	input  logic [XLEN-1:0]           dividend_norm_i,
	input  logic [XLEN-1:0]           divisor_norm_i,
	input  logic [$clog2(XLEN)-1:0]   lzc_diff_i,
	input  quot_digit_e               digit_i,
	input  quot_digit_e               init_digit_i,
	output logic [XLEN+REM_GUARD-1:0] rem_sum_o,
	output logic [XLEN+REM_GUARD-1:0] rem_carry_o,
	output quot_digit_e               prev_digit_o,
	output logic [XLEN-1:0]           quot_o,
	output logic [XLEN-1:0]           quot_m1_o,
	output logic                      iter_done_o
);

	localparam int RW    = XLEN + REM_GUARD;
	localparam int LZC_W = $clog2(XLEN);

	logic [RW-1:0]    rem_init;
	logic [RW-1:0]    csa_x1;
	logic [RW-1:0]    csa_x2;
	logic [RW-1:0]    csa_x3;
	logic [RW-1:0]    csa_maj;
	logic             pos_digit;
	logic [LZC_W:0]   cnt_init;
	logic [LZC_W-1:0] cnt_q; // steps left after the current one
	logic [XLEN-1:0]  quot_nxt;
	logic [XLEN-1:0]  quot_m1_nxt;

	// an odd shift distance is absorbed here so every step moves two bits
	assign rem_init = lzc_diff_i[0] ? {{(REM_GUARD-1){1'b0}}, 1'b0, dividend_norm_i}
	                                : {{(REM_GUARD-1){1'b0}}, dividend_norm_i, 1'b0};
	assign cnt_init = ({1'b0, lzc_diff_i} + 1'b1) >> 1; // half the difference, rounded up

	assign csa_x1    = {rem_sum_o[RW-3:0], 2'b00}; // 4w in carry-save form
	assign csa_x2    = {rem_carry_o[RW-3:0], 2'b00};
	assign pos_digit = (prev_digit_o == POS1) | (prev_digit_o == POS2);

	always_comb begin
		unique case (prev_digit_o)
			NEG2:    csa_x3 = {divisor_norm_i, {REM_GUARD{1'b0}}};
			NEG1:    csa_x3 = {1'b0, divisor_norm_i, {(REM_GUARD-1){1'b0}}};
			POS1:    csa_x3 = ~{1'b0, divisor_norm_i, {(REM_GUARD-1){1'b0}}}; // +1 enters via carry lsb
			POS2:    csa_x3 = ~{divisor_norm_i, {REM_GUARD{1'b0}}};
			default: csa_x3 = '0;
		endcase
	end

	assign csa_maj = (csa_x1 & csa_x2) | (csa_x1 & csa_x3) | (csa_x2 & csa_x3);

	// on-the-fly conversion keeps both q and q-1 so negative digits never borrow
	always_comb begin
		unique case (prev_digit_o)
			POS2: begin quot_nxt = {quot_o[XLEN-3:0], 2'b10}; quot_m1_nxt = {quot_o[XLEN-3:0], 2'b01}; end
			POS1: begin quot_nxt = {quot_o[XLEN-3:0], 2'b01}; quot_m1_nxt = {quot_o[XLEN-3:0], 2'b00}; end
			NEG1: begin quot_nxt = {quot_m1_o[XLEN-3:0], 2'b11}; quot_m1_nxt = {quot_m1_o[XLEN-3:0], 2'b10}; end
			NEG2: begin quot_nxt = {quot_m1_o[XLEN-3:0], 2'b10}; quot_m1_nxt = {quot_m1_o[XLEN-3:0], 2'b01}; end
			default: begin quot_nxt = {quot_o[XLEN-3:0], 2'b00}; quot_m1_nxt = {quot_m1_o[XLEN-3:0], 2'b11}; end
		endcase
	end

	always_ff @(posedge clock) begin
		if (state_i == INIT) begin
			rem_sum_o   <= rem_init;
			rem_carry_o <= '0;
			quot_o      <= '0;
			quot_m1_o   <= '1; // zero minus one
		end else if (state_i == ITER) begin
			rem_sum_o   <= csa_x1 ^ csa_x2 ^ csa_x3;
			rem_carry_o <= {csa_maj[RW-2:0], pos_digit};
			quot_o      <= quot_nxt;
			quot_m1_o   <= quot_m1_nxt;
		end
	end

	always_ff @(posedge clock) begin
		if (reset_i) begin
			cnt_q        <= '0;
			prev_digit_o <= ZERO;
		end else if (state_i == INIT) begin
			cnt_q        <= cnt_init[LZC_W-1:0];
			prev_digit_o <= init_digit_i; // from the pre-comparison
		end else if (state_i == ITER) begin
			cnt_q        <= cnt_q - 1'b1;
			prev_digit_o <= digit_i; // selected on the remainder this step produces
		end
	end

	assign iter_done_o = (state_i == ITER) && (cnt_q == '0);

endmodule

// File: rtl/div_qds.sv
`timescale 1ns/1ps

module div_qds import srt_div_pkg::*; #(
	parameter int XLEN = 32
) (
	input  logic [XLEN-1:0] divisor_norm_i,
	input  logic [7:0]      rem_sum_top_i,
	input  logic [7:0]      rem_carry_top_i,
	input  quot_digit_e     prev_digit_i,
	input  logic [4:0]      init_rem_top_i,
	output quot_digit_e     digit_o,
	output quot_digit_e     init_digit_o
);

	logic [7:0]        mult_top; // top of the digit multiple about to be added
	logic [7:0]        est; // next remainder estimate in 1/32 units of 4w
	logic signed [6:0] y; // the same estimate floored to 1/16 units
	logic signed [6:0] init_y;
	logic signed [6:0] m_pos2;
	logic signed [6:0] m_pos1;
	logic signed [6:0] m_zero;
	logic signed [6:0] m_neg1;

	// predict the next remainder so the digit is ready when the step lands
	always_comb begin
		unique case (prev_digit_i)
			NEG2:    mult_top = divisor_norm_i[XLEN-1 -: 8]; // +2d
			NEG1:    mult_top = {1'b0, divisor_norm_i[XLEN-1 -: 7]}; // +d
			POS1:    mult_top = ~{1'b0, divisor_norm_i[XLEN-1 -: 7]}; // -d without the +1
			POS2:    mult_top = ~divisor_norm_i[XLEN-1 -: 8];
			default: mult_top = 8'h00;
		endcase
	end

	assign est    = rem_sum_top_i + rem_carry_top_i + mult_top; // truncation error below 3/32
	assign y      = $signed(est[7:1]);
	assign init_y = $signed({2'b00, init_rem_top_i}); // initial remainder is exact and positive

	// thresholds in 1/16 units, picked by the three divisor bits under the leading one
	always_comb begin
		unique case (divisor_norm_i[XLEN-2 -: 3])
			3'b000: begin m_pos2 = 7'sd12; m_pos1 = 7'sd4; m_zero = -7'sd4; m_neg1 = -7'sd13; end
			3'b001: begin m_pos2 = 7'sd14; m_pos1 = 7'sd4; m_zero = -7'sd6; m_neg1 = -7'sd15; end
			3'b010: begin m_pos2 = 7'sd15; m_pos1 = 7'sd4; m_zero = -7'sd6; m_neg1 = -7'sd16; end
			3'b011: begin m_pos2 = 7'sd16; m_pos1 = 7'sd4; m_zero = -7'sd6; m_neg1 = -7'sd18; end
			3'b100: begin m_pos2 = 7'sd18; m_pos1 = 7'sd6; m_zero = -7'sd6; m_neg1 = -7'sd20; end
			3'b101: begin m_pos2 = 7'sd20; m_pos1 = 7'sd6; m_zero = -7'sd8; m_neg1 = -7'sd20; end
			3'b110: begin m_pos2 = 7'sd20; m_pos1 = 7'sd8; m_zero = -7'sd8; m_neg1 = -7'sd22; end
			default: begin m_pos2 = 7'sd24; m_pos1 = 7'sd8; m_zero = -7'sd8; m_neg1 = -7'sd24; end
		endcase
	end

	// regions 000 and 100 have the tight m[-1] edge, which the 1/16 floor of est still meets
	always_comb begin
		if (y >= m_pos2) begin
			digit_o = POS2;
		end else if (y >= m_pos1) begin
			digit_o = POS1;
		end else if (y >= m_zero) begin
			digit_o = ZERO;
		end else if (y >= m_neg1) begin
			digit_o = NEG1;
		end else begin
			digit_o = NEG2;
		end
	end

	// first digit only ever needs the positive comparisons
	always_comb begin
		if (init_y >= m_pos2) begin
			init_digit_o = POS2;
		end else if (init_y >= m_pos1) begin
			init_digit_o = POS1;
		end else begin
			init_digit_o = ZERO;
		end
	end

endmodule

// File: rtl/div_prescale.sv
`timescale 1ns/1ps

module div_prescale import srt_div_pkg::*; #(
	parameter int XLEN = 32
) (
	input  logic                    clock,
	input  logic                    reset_i,
	input  div_state_e              state_i,
	input  logic                    accept_i,
	input  logic                    signed_i,
	input  logic [XLEN-1:0]         dividend_i,
	input  logic [XLEN-1:0]         divisor_i,
	output logic [XLEN-1:0]         dividend_norm_o,
	output logic [XLEN-1:0]         divisor_norm_o,
	output logic [$clog2(XLEN)-1:0] dividend_lzc_o,
	output logic [$clog2(XLEN)-1:0] divisor_lzc_o,
	output logic                    rem_neg_o,
	output logic                    quot_neg_o,
	output logic                    div_zero_o,
	output logic                    too_small_o
);

	localparam int LZC_W = $clog2(XLEN);

	logic             dividend_neg; // operand signs only count in signed mode
	logic             divisor_neg;
	logic [XLEN-1:0]  dividend_abs_q;
	logic [XLEN-1:0]  divisor_abs_q;
	logic [LZC_W-1:0] dividend_cnt;
	logic [LZC_W-1:0] divisor_cnt;
	logic             dividend_zero;
	logic             divisor_zero;

	assign dividend_neg = signed_i & dividend_i[XLEN-1];
	assign divisor_neg  = signed_i & divisor_i[XLEN-1];

	div_lzc #(.XLEN(XLEN)) u_lzc_dividend (
		.value_i (dividend_abs_q),
		.count_o (dividend_cnt),
		.zero_o  (dividend_zero)
	);

	div_lzc #(.XLEN(XLEN)) u_lzc_divisor (
		.value_i (divisor_abs_q),
		.count_o (divisor_cnt),
		.zero_o  (divisor_zero)
	);

	always_ff @(posedge clock) begin
		if (accept_i) begin
			dividend_abs_q <= dividend_neg ? -dividend_i : dividend_i; // most negative stays 2^(XLEN-1)
			divisor_abs_q  <= divisor_neg ? -divisor_i : divisor_i;
		end
		if (state_i == NORM) begin
			dividend_norm_o <= dividend_abs_q << dividend_cnt; // leading one now at the msb
			divisor_norm_o  <= divisor_abs_q << divisor_cnt;
			dividend_lzc_o  <= dividend_cnt;
			divisor_lzc_o   <= divisor_cnt; // also the final remainder shift
		end
	end

	always_ff @(posedge clock) begin
		if (reset_i) begin
			rem_neg_o   <= 1'b0;
			quot_neg_o  <= 1'b0;
			div_zero_o  <= 1'b0;
			too_small_o <= 1'b0;
		end else if (accept_i) begin
			rem_neg_o  <= dividend_neg; // remainder takes the dividend sign
			quot_neg_o <= dividend_neg ^ divisor_neg;
		end else if (state_i == NORM) begin
			div_zero_o  <= divisor_zero;
			too_small_o <= (divisor_cnt < dividend_cnt) | dividend_zero; // divisor is wider
			if (divisor_zero) begin
				quot_neg_o <= 1'b0; // all-ones quotient is returned unsigned
			end
		end
	end

endmodule

// File: rtl/div_lzc.sv
`timescale 1ns/1ps

module div_lzc #(
	parameter int XLEN = 32
) (
	input  logic [XLEN-1:0]         value_i,
	output logic [$clog2(XLEN)-1:0] count_o,
	output logic                    zero_o
);

	localparam int LZC_W = $clog2(XLEN);

	logic [XLEN-1:0] vec; // working copy, shifted as zero halves are found

	always_comb begin
		vec = value_i;
		count_o = '0;
		for (int i = LZC_W - 1; i >= 0; i--) begin
			if ((vec >> (XLEN - (1 << i))) == '0) begin // upper 2^i bits all clear
				count_o[i] = 1'b1; // leading one sits below this window
				vec = vec << (1 << i); // move the rest up for the next halving
			end
		end
	end

	assign zero_o = (value_i == '0); // count is meaningless in this case

endmodule

// File: rtl/srt_div_pkg.sv
package srt_div_pkg;

	// controller state, one-hot so each stage can decode a single bit
	typedef enum logic [5:0] {
		IDLE = 6'b000001, // waiting for an operand pair
		NORM = 6'b000010, // leading-zero count and normalization
		INIT = 6'b000100, // load remainder, first digit and iteration count
		ITER = 6'b001000, // one radix-4 step per cycle
		FIX  = 6'b010000, // resolve the carry-save remainder and correct
		DONE = 6'b100000  // result held until the consumer takes it
	} div_state_e;

	// radix-4 quotient digit in the redundant set {-2..+2}, one-hot
	typedef enum logic [4:0] {
		NEG2 = 5'b00001,
		NEG1 = 5'b00010,
		ZERO = 5'b00100,
		POS1 = 5'b01000,
		POS2 = 5'b10000
	} quot_digit_e;

	// extra remainder bits above the operand: sign, two shift bits and the odd-shift bit
	localparam int REM_GUARD = 4;

endpackage
